/* arm_pkg.sv */
`default_nettype none

package arm_pkg;

    typedef logic [31:0] word_t;      // data or instruction word
    typedef logic [3:0]  reg_addr_t;  // index into the 16 registers
    typedef logic [1:0]  mode_t;      // instruction class, bits 27:26
    typedef logic [3:0]  opcode_t;    // data-processing opcode, bits 24:21
    typedef logic [3:0]  exe_cmd_t;   // command handed to the execute stage
    typedef logic [3:0]  cond_t;      // condition field, bits 31:28
    typedef logic [3:0]  flags_t;     // N, Z, C, V from the status register

    localparam mode_t arithmetic_type = 2'b00;
    localparam mode_t memory_type     = 2'b01;
    localparam mode_t branch_type     = 2'b10;

    // ldr and str get their own codes so every opcode decodes uniquely
    localparam opcode_t and_op = 4'b0000;
    localparam opcode_t eor    = 4'b0001;
    localparam opcode_t sub    = 4'b0010;
    localparam opcode_t ldr    = 4'b0011;
    localparam opcode_t add    = 4'b0100;
    localparam opcode_t adc    = 4'b0101;
    localparam opcode_t sbc    = 4'b0110;
    localparam opcode_t str    = 4'b0111;
    localparam opcode_t tst    = 4'b1000;
    localparam opcode_t cmp    = 4'b1010;
    localparam opcode_t orr    = 4'b1100;
    localparam opcode_t mov    = 4'b1101;
    localparam opcode_t movn   = 4'b1111;

    localparam exe_cmd_t exe_nop  = 4'b0000; // bubble, nothing to do
    localparam exe_cmd_t mov_exe  = 4'b0001;
    localparam exe_cmd_t add_exe  = 4'b0010;
    localparam exe_cmd_t adc_exe  = 4'b0011;
    localparam exe_cmd_t sub_exe  = 4'b0100;
    localparam exe_cmd_t sbc_exe  = 4'b0101;
    localparam exe_cmd_t and_exe  = 4'b0110;
    localparam exe_cmd_t orr_exe  = 4'b0111;
    localparam exe_cmd_t eor_exe  = 4'b1000;
    localparam exe_cmd_t movn_exe = 4'b1001;
    localparam exe_cmd_t cmp_exe  = 4'b1010;
    localparam exe_cmd_t tst_exe  = 4'b1011;
    localparam exe_cmd_t ldr_exe  = 4'b1100;
    localparam exe_cmd_t str_exe  = 4'b1101;
    localparam exe_cmd_t mul_exe  = 4'b1110;

    localparam cond_t cond_eq = 4'b0000;
    localparam cond_t cond_ne = 4'b0001;
    localparam cond_t cond_cs = 4'b0010;
    localparam cond_t cond_cc = 4'b0011;
    localparam cond_t cond_mi = 4'b0100;
    localparam cond_t cond_pl = 4'b0101;
    localparam cond_t cond_vs = 4'b0110;
    localparam cond_t cond_vc = 4'b0111;
    localparam cond_t cond_hi = 4'b1000;
    localparam cond_t cond_ls = 4'b1001;
    localparam cond_t cond_ge = 4'b1010;
    localparam cond_t cond_lt = 4'b1011;
    localparam cond_t cond_gt = 4'b1100;
    localparam cond_t cond_le = 4'b1101;
    localparam cond_t cond_al = 4'b1110;

    localparam int flag_n = 3;
    localparam int flag_z = 2;
    localparam int flag_c = 1;
    localparam int flag_v = 0;

    localparam logic [3:0] mul_pattern = 4'b1001; // bits 7:4 of a multiply

endpackage

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit import arm_pkg::*; (
    input  mode_t      mode,
    input  opcode_t    opcode,
    input  logic       s,
    input  logic       imm_bit,
    input  logic [3:0] mul_bits,
    output exe_cmd_t   exe_cmd,
    output logic       mem_read,
    output logic       mem_write,
    output logic       wb_en,
    output logic       branch_taken,
    output logic       status_we,
    output logic       ignore_hazard,
    output logic       is_mul
);

    assign status_we = s; // the S bit goes to the status register unchanged

    always_comb begin
        exe_cmd       = exe_nop;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        wb_en         = 1'b0;
        branch_taken  = 1'b0;
        ignore_hazard = 1'b0;
        is_mul        = 1'b0;

        case (mode)
            arithmetic_type: begin
                wb_en = 1'b1; // cleared below for cmp, tst and str
                case (opcode)
                    mov: begin
                        exe_cmd       = mov_exe;
                        ignore_hazard = 1'b1; // Rn is not an operand
                    end
                    movn: begin
                        exe_cmd       = movn_exe;
                        ignore_hazard = 1'b1;
                    end
                    add: exe_cmd = add_exe;
                    adc: exe_cmd = adc_exe;
                    sub: exe_cmd = sub_exe;
                    sbc: exe_cmd = sbc_exe;
                    and_op: begin
                        if (mul_bits == mul_pattern && !imm_bit) begin
                            exe_cmd = mul_exe;
                            is_mul  = 1'b1;
                        end else begin
                            exe_cmd = and_exe;
                        end
                    end
                    orr: exe_cmd = orr_exe;
                    eor: exe_cmd = eor_exe;
                    cmp: begin
                        exe_cmd = cmp_exe;
                        wb_en   = 1'b0;
                    end
                    tst: begin
                        exe_cmd = tst_exe;
                        wb_en   = 1'b0;
                    end
                    ldr: exe_cmd = ldr_exe;
                    str: begin
                        exe_cmd = str_exe;
                        wb_en   = 1'b0;
                    end
                    default: wb_en = 1'b0; // unused opcode behaves as a nop
                endcase
            end

            memory_type: begin
                exe_cmd = add_exe; // address is base plus offset
                if (s) begin
                    mem_read = 1'b1;
                    wb_en    = 1'b1;
                end else begin
                    mem_write = 1'b1;
                end
            end

            branch_type: begin
                branch_taken  = 1'b1;
                ignore_hazard = 1'b1;
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* condition_check.sv */
`timescale 1ns/1ps
`default_nettype none

module condition_check import arm_pkg::*; (
    input  cond_t  cond,
    input  flags_t flags,
    output logic   cond_pass
);

    logic n;
    logic z;
    logic c;
    logic v;

    assign n = flags[flag_n];
    assign z = flags[flag_z];
    assign c = flags[flag_c];
    assign v = flags[flag_v];

    always_comb begin
        case (cond)
            cond_eq: cond_pass = z;
            cond_ne: cond_pass = !z;
            cond_cs: cond_pass = c;
            cond_cc: cond_pass = !c;
            cond_mi: cond_pass = n;
            cond_pl: cond_pass = !n;
            cond_vs: cond_pass = v;
            cond_vc: cond_pass = !v;
            cond_hi: cond_pass = c && !z;
            cond_ls: cond_pass = !c || z;
            cond_ge: cond_pass = (n == v);         // signed greater or equal
            cond_lt: cond_pass = (n != v);
            cond_gt: cond_pass = !z && (n == v);
            cond_le: cond_pass = z || (n != v);
            default: cond_pass = 1'b1;             // al and 1111 always execute
        endcase
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import arm_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t src1,
    input  reg_addr_t src2,
    input  logic      write,
    input  reg_addr_t dest,
    input  word_t     write_data,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [16];

    // one write per cycle from the write-back stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (write) begin
            regs[dest] <= write_data;
        end
    end

    // reads see the array directly, so a write shows up right after its edge
    assign rd1 = regs[src1];
    assign rd2 = regs[src2];

endmodule

`default_nettype wire

/* hazard_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_detect import arm_pkg::*; (
    input  reg_addr_t src1,
    input  reg_addr_t src2,
    input  logic      src2_used,
    input  logic      ignore_hazard,
    input  reg_addr_t exe_dest,
    input  logic      exe_wb_en,
    input  reg_addr_t mem_dest,
    input  logic      mem_wb_en,
    output logic      stall
);

    logic src1_hit;
    logic src2_hit;

    // a source conflicts with any later stage that will still write it
    assign src1_hit = !ignore_hazard &&
                      ((exe_wb_en && src1 == exe_dest) ||
                       (mem_wb_en && src1 == mem_dest));

    assign src2_hit = src2_used &&
                      ((exe_wb_en && src2 == exe_dest) ||
                       (mem_wb_en && src2 == mem_dest));

    assign stall = src1_hit || src2_hit; // no forwarding, so wait it out

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import arm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  word_t       instruction,
    input  word_t       pc,
    input  flags_t      flags,
    input  logic        flush,
    input  logic        wb_write,
    input  reg_addr_t   wb_dest,
    input  word_t       wb_value,
    input  reg_addr_t   exe_dest,
    input  logic        exe_wb_en,
    input  reg_addr_t   mem_dest,
    input  logic        mem_wb_en,
    output logic        stall,
    output exe_cmd_t    exe_cmd,
    output logic        mem_read,
    output logic        mem_write,
    output logic        wb_en,
    output logic        branch_taken,
    output logic        status_we,
    output logic        imm,
    output logic        is_mul,
    output word_t       val_rn,
    output word_t       val_rm,
    output reg_addr_t   dest,
    output logic [11:0] shift_operand,
    output logic [23:0] signed_imm24,
    output word_t       pc_out
);

    cond_t     cond;
    mode_t     mode;
    opcode_t   opcode;
    logic      imm_bit;
    logic      s;
    reg_addr_t rn;
    reg_addr_t rd;
    reg_addr_t rm;
    logic      is_store;
    reg_addr_t src2;
    logic      src2_used;
    logic      bubble;
    logic      cond_pass;
    logic      ignore_hazard;
    exe_cmd_t  cu_exe_cmd;
    logic      cu_mem_read;
    logic      cu_mem_write;
    logic      cu_wb_en;
    logic      cu_branch_taken;
    logic      cu_status_we;
    logic      cu_is_mul;
    word_t     rd1;
    word_t     rd2;

    assign cond    = instruction[31:28];
    assign mode    = instruction[27:26];
    assign imm_bit = instruction[25];
    assign opcode  = instruction[24:21];
    assign s       = instruction[20];
    assign rn      = instruction[19:16];
    assign rd      = instruction[15:12];
    assign rm      = instruction[3:0];

    // a store reads Rd as the data to write, everything else reads Rm
    assign is_store  = (mode == memory_type) && !s;
    assign src2      = is_store ? rd : rm;
    assign src2_used = !imm_bit || is_store;

    control_unit control_unit_inst (
        .mode          (mode),
        .opcode        (opcode),
        .s             (s),
        .imm_bit       (imm_bit),
        .mul_bits      (instruction[7:4]),
        .exe_cmd       (cu_exe_cmd),
        .mem_read      (cu_mem_read),
        .mem_write     (cu_mem_write),
        .wb_en         (cu_wb_en),
        .branch_taken  (cu_branch_taken),
        .status_we     (cu_status_we),
        .ignore_hazard (ignore_hazard),
        .is_mul        (cu_is_mul)
    );

    condition_check condition_check_inst (
        .cond      (cond),
        .flags     (flags),
        .cond_pass (cond_pass)
    );

    register_file register_file_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .src1       (rn),
        .src2       (src2),
        .write      (wb_write),
        .dest       (wb_dest),
        .write_data (wb_value),
        .rd1        (rd1),
        .rd2        (rd2)
    );

    hazard_detect hazard_detect_inst (
        .src1          (rn),
        .src2          (src2),
        .src2_used     (src2_used),
        .ignore_hazard (ignore_hazard),
        .exe_dest      (exe_dest),
        .exe_wb_en     (exe_wb_en),
        .mem_dest      (mem_dest),
        .mem_wb_en     (mem_wb_en),
        .stall         (stall)
    );

    assign bubble = stall || flush || !cond_pass;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_cmd      <= exe_nop;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            wb_en        <= 1'b0;
            branch_taken <= 1'b0;
            status_we    <= 1'b0;
            is_mul       <= 1'b0;
            imm          <= 1'b0;
        end else begin
            exe_cmd      <= bubble ? exe_nop : cu_exe_cmd;
            mem_read     <= cu_mem_read && !bubble;
            mem_write    <= cu_mem_write && !bubble;
            wb_en        <= cu_wb_en && !bubble;
            branch_taken <= cu_branch_taken && !bubble;
            status_we    <= cu_status_we && !bubble;
            is_mul       <= cu_is_mul && !bubble;
            imm          <= imm_bit; // operand kind, not a strobe
        end
    end

    // payload travels along even in a bubble, the strobes decide if it matters
    always_ff @(posedge clk) begin
        val_rn        <= rd1;
        val_rm        <= rd2;
        dest          <= rd;
        shift_operand <= instruction[11:0];
        signed_imm24  <= instruction[23:0];
        pc_out        <= pc;
    end

endmodule

`default_nettype wire

/* decode_stage_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assert import arm_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     flush,
    input exe_cmd_t exe_cmd,
    input logic     mem_read,
    input logic     mem_write,
    input logic     wb_en,
    input logic     branch_taken,
    input logic     status_we,
    input logic     is_mul
);

    logic ctrl_idle;

    assign ctrl_idle = (exe_cmd == exe_nop) && !mem_read && !mem_write && !wb_en &&
                       !branch_taken && !status_we && !is_mul;

    no_read_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high in the same cycle");

    // a stall or flush at one edge leaves a bubble in ID/EX after it
    bubble_after_stall_or_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (stall || flush) |=> ctrl_idle)
        else $error("control outputs are not zero after a stall or flush");

    idle_in_reset: assert property (@(posedge clk) !rst_n |-> ctrl_idle)
        else $error("control outputs are not zero during reset");

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_inst (.*);

`default_nettype wire

/* tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import arm_pkg::*; ();

    logic        clk;
    logic        rst_n;
    word_t       instruction;
    word_t       pc;
    flags_t      flags;
    logic        flush;
    logic        wb_write;
    reg_addr_t   wb_dest;
    word_t       wb_value;
    reg_addr_t   exe_dest;
    logic        exe_wb_en;
    reg_addr_t   mem_dest;
    logic        mem_wb_en;
    logic        stall;
    exe_cmd_t    exe_cmd;
    logic        mem_read;
    logic        mem_write;
    logic        wb_en;
    logic        branch_taken;
    logic        status_we;
    logic        imm;
    logic        is_mul;
    word_t       val_rn;
    word_t       val_rm;
    reg_addr_t   dest;
    logic [11:0] shift_operand;
    logic [23:0] signed_imm24;
    word_t       pc_out;

    logic [7:0]  kind;      // W for a register write step, D for a checked decode
    logic        exp_stall;
    exe_cmd_t    exp_cmd;
    logic [5:0]  exp_ctrl;  // mem_read mem_write wb_en branch_taken status_we is_mul
    word_t       exp_rn;
    word_t       exp_rm;
    logic [5:0]  ctrl_out;
    int          step_total;
    int          step_no;
    int          step_errors;
    int          pass_count;
    int          fail_count;
    bit          loaded;

    assign ctrl_out = {mem_read, mem_write, wb_en, branch_taken, status_we, is_mul};

    decode_stage decode_stage_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic clear_inputs();
        rst_n       = 1'b0;
        instruction = '0;
        pc          = '0;
        flags       = '0;
        flush       = 1'b0;
        wb_write    = 1'b0;
        wb_dest     = '0;
        wb_value    = '0;
        exe_dest    = '0;
        exe_wb_en   = 1'b0;
        mem_dest    = '0;
        mem_wb_en   = 1'b0;
    endtask

    // fills the DUT inputs and the expected values from the next data line
    task automatic read_step(input int fd, output bit got);
        int               code;
        logic [8*160-1:0] rest;
        got = 1'b0;
        code = $fscanf(fd, " %s", kind);
        while (code == 1 && kind == "#") begin
            code = $fgets(rest, fd);
            code = $fscanf(fd, " %s", kind);
        end
        if (code == 1) begin
            code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %b %h %h",
                           instruction, pc, flags, flush, wb_write, wb_dest, wb_value,
                           exe_dest, exe_wb_en, mem_dest, mem_wb_en,
                           exp_stall, exp_cmd, exp_ctrl, exp_rn, exp_rm);
            got = (code == 16);
        end
    endtask

    task automatic mismatch(input string field, input word_t got, input word_t want);
        $display("[FAIL] %0d ns: step %0d %s is %h, expected %h",
                 $time, step_no, field, got, want);
        step_errors++;
    endtask

    // registered fields follow the instruction slicing of the ID/EX register
    task automatic check_step();
        step_errors = 0;
        if (stall !== exp_stall) mismatch("stall", 32'(stall), 32'(exp_stall));
        if (exe_cmd !== exp_cmd) mismatch("exe_cmd", 32'(exe_cmd), 32'(exp_cmd));
        if (ctrl_out !== exp_ctrl) mismatch("control", 32'(ctrl_out), 32'(exp_ctrl));
        if (imm !== instruction[25]) mismatch("imm", 32'(imm), 32'(instruction[25]));
        if (val_rn !== exp_rn) mismatch("val_rn", val_rn, exp_rn);
        if (val_rm !== exp_rm) mismatch("val_rm", val_rm, exp_rm);
        if (dest !== instruction[15:12]) mismatch("dest", 32'(dest), 32'(instruction[15:12]));
        if (shift_operand !== instruction[11:0])
            mismatch("shift_operand", 32'(shift_operand), 32'(instruction[11:0]));
        if (signed_imm24 !== instruction[23:0])
            mismatch("signed_imm24", 32'(signed_imm24), 32'(instruction[23:0]));
        if (pc_out !== pc) mismatch("pc_out", pc_out, pc);
        if (step_errors == 0) begin
            pass_count++;
            $display("step %0d: ok", step_no);
        end else begin
            fail_count++;
            $display("step %0d: %0d mismatches", step_no, step_errors);
        end
    endtask

    initial begin
        int fd;
        bit got;
        fd = $fopen("decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open decode_patterns.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            step_total = 0;
            read_step(fd, got);
            while (got) begin
                step_total++;
                read_step(fd, got);
            end
            $fclose(fd);
            clear_inputs();
            pass_count = 0;
            fail_count = 0;
            step_no    = 0;
            loaded     = 1'b1;
            repeat (2) @(posedge clk);
            #5;
            rst_n = 1'b1;
            fd = $fopen("decode_patterns.txt", "r");
            read_step(fd, got); // inputs change 5 ns after the edge
            while (got) begin
                step_no++;
                @(posedge clk);
                #1;
                if (kind == "D") check_step();
                #4;
                read_step(fd, got);
            end
            $fclose(fd);
            $display("decode steps: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0 && pass_count > 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (loaded);
        #((step_total + 10) * 100); // reset plus one clock per step, with margin
        $display("simulation timed out before all %0d steps were done", step_total);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* decode_patterns.txt */
# kind instr pc flags flush wb_write wb_dest wb_value exe_dest exe_wb_en mem_dest mem_wb_en
# expected stall exe_cmd ctrl(mem_read mem_write wb_en branch_taken status_we is_mul) rn rm
W 00000000 00000000 0 0 1 1 11110001 0 0 0 0 0 0 000000 00000000 00000000
W 00000000 00000000 0 0 1 2 22220002 0 0 0 0 0 0 000000 00000000 00000000
W 00000000 00000000 0 0 1 5 cafe0005 0 0 0 0 0 0 000000 00000000 00000000
D E1A13002 00000004 0 0 0 0 00000000 0 0 0 0 0 1 001000 11110001 22220002
D E1F13002 00000008 0 0 0 0 00000000 0 0 0 0 0 9 001010 11110001 22220002
D E0813002 0000000c 0 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002
D E0B13002 00000010 0 0 0 0 00000000 0 0 0 0 0 3 001010 11110001 22220002
D E0413002 00000014 0 0 0 0 00000000 0 0 0 0 0 4 001000 11110001 22220002
D E0D13002 00000018 0 0 0 0 00000000 0 0 0 0 0 5 001010 11110001 22220002
D E0013002 0000001c 0 0 0 0 00000000 0 0 0 0 0 6 001000 11110001 22220002
D E1813002 00000020 0 0 0 0 00000000 0 0 0 0 0 7 001000 11110001 22220002
D E0213002 00000024 0 0 0 0 00000000 0 0 0 0 0 8 001000 11110001 22220002
D E1513002 00000028 0 0 0 0 00000000 0 0 0 0 0 a 000010 11110001 22220002
D E1113002 0000002c 0 0 0 0 00000000 0 0 0 0 0 b 000010 11110001 22220002
D E0613002 00000030 0 0 0 0 00000000 0 0 0 0 0 c 001000 11110001 22220002
D E0E13002 00000034 0 0 0 0 00000000 0 0 0 0 0 d 000000 11110001 22220002
D E0013092 00000038 0 0 0 0 00000000 0 0 0 0 0 e 001001 11110001 22220002
D E2013092 0000003c 0 0 0 0 00000000 0 0 0 0 0 6 001000 11110001 22220002
D E6913004 00000040 0 0 0 0 00000000 0 0 0 0 0 2 101010 11110001 00000000
D E6815004 00000044 0 0 0 0 00000000 0 0 0 0 0 2 010000 11110001 cafe0005
D E8234567 00000048 0 0 0 0 00000000 0 0 0 0 0 0 000100 00000000 00000000
D 00813002 0000004c 0 0 0 0 00000000 0 0 0 0 0 0 000000 11110001 22220002
D 00813002 00000050 4 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002
D A0813002 00000054 8 0 0 0 00000000 0 0 0 0 0 0 000000 11110001 22220002
D A0813002 00000058 9 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002
D 80813002 0000005c 2 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002
D 80813002 00000060 6 0 0 0 00000000 0 0 0 0 0 0 000000 11110001 22220002
D D0813002 00000064 0 0 0 0 00000000 0 0 0 0 0 0 000000 11110001 22220002
D D0813002 00000068 8 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002
D F0813002 0000006c 0 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002
D E0813002 00000070 0 0 0 0 00000000 1 1 0 0 1 0 000000 11110001 22220002
D E0813002 00000074 0 0 0 0 00000000 0 0 2 1 1 0 000000 11110001 22220002
D E1A13002 00000078 0 0 0 0 00000000 1 1 0 0 0 1 001000 11110001 22220002
D E2813002 0000007c 0 0 0 0 00000000 0 0 2 1 0 2 001000 11110001 22220002
D E6815004 00000080 0 0 0 0 00000000 5 1 0 0 1 0 000000 11110001 cafe0005
D E0813002 00000084 0 1 0 0 00000000 0 0 0 0 0 0 000000 11110001 22220002
D E0813002 00000088 0 0 0 0 00000000 0 0 0 0 0 2 001000 11110001 22220002

/* list.f */
arm_pkg.sv
control_unit.sv
condition_check.sv
register_file.sv
hazard_detect.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage \
    -f list.f -o tb_decode_stage_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_decode_stage_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
